// File: Makefile
TOP = csr_unit_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f hdl/*.sv tb/*.sv include/*.svh
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

// File: build.f
+incdir+include
hdl/csr_pkg.sv
hdl/csr_op_unit.sv
hdl/csr_regfile.sv
hdl/trap_ctrl.sv
hdl/machine_timer.sv
hdl/csr_unit.sv
tb/csr_unit_tb.sv

// File: hdl/csr_op_unit.sv
`timescale 1ns/1ps

module csr_op_unit (
	input  csr_pkg::csr_op_t op,
	input  logic [31:0]      src,
	input  logic [31:0]      old,
	output logic [31:0]      new_val,
	output logic             wr_en
);
	import csr_pkg::*;

	// set and clear with a zero source must not write
	always_comb
	begin
		new_val = old;
		wr_en   = 1'b0;
		case (op)
			RW:
			begin
				new_val = src;
				wr_en   = 1'b1;
			end
			RS:
			begin
				new_val = old | src;
				wr_en   = |src;
			end
			RC:
			begin
				new_val = old & ~src;
				wr_en   = |src;
			end
			default:
			begin
				new_val = old;	// no op, keep the value
				wr_en   = 1'b0;
			end
		endcase
	end

endmodule

// File: hdl/csr_pkg.sv
package csr_pkg;

	//////////////////////////////////////////////////
	// privilege modes and csr ops

	typedef enum logic [1:0]
	{
		U = 2'd0,
		S = 2'd1,
		M = 2'd3
	} mode_t;

	typedef enum logic [1:0]
	{
		NONE = 2'd0,
		RW   = 2'd1,
		RS   = 2'd2,
		RC   = 2'd3
	} csr_op_t;

	//////////////////////////////////////////////////
	// csr addresses

	localparam logic [11:0] CSR_MSTATUS   = 12'h300;
	localparam logic [11:0] CSR_MISA      = 12'h301;
	localparam logic [11:0] CSR_MEDELEG   = 12'h302;
	localparam logic [11:0] CSR_MIDELEG   = 12'h303;
	localparam logic [11:0] CSR_MIE       = 12'h304;
	localparam logic [11:0] CSR_MTVEC     = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
	localparam logic [11:0] CSR_MEPC      = 12'h341;
	localparam logic [11:0] CSR_MCAUSE    = 12'h342;
	localparam logic [11:0] CSR_MTVAL     = 12'h343;
	localparam logic [11:0] CSR_MIP       = 12'h344;
	localparam logic [11:0] CSR_STVEC     = 12'h105;
	localparam logic [11:0] CSR_SEPC      = 12'h141;
	localparam logic [11:0] CSR_SCAUSE    = 12'h142;
	localparam logic [11:0] CSR_STVAL     = 12'h143;
	localparam logic [11:0] CSR_MVENDORID = 12'hF11;
	localparam logic [11:0] CSR_MARCHID   = 12'hF12;
	localparam logic [11:0] CSR_MIMPID    = 12'hF13;
	localparam logic [11:0] CSR_MHARTID   = 12'hF14;
	localparam logic [11:0] CSR_TIME      = 12'hC01;	// read-only view of mtime
	localparam logic [11:0] CSR_TIMEH     = 12'hC81;
	localparam logic [11:0] CSR_MTIMECMP  = 12'h7C0;	// custom, no bus for the timer
	localparam logic [11:0] CSR_MTIMECMPH = 12'h7C1;

	//////////////////////////////////////////////////
	// cause codes

	localparam logic [4:0] EXC_I_MISALIGNED = 5'd0;
	localparam logic [4:0] EXC_ILLEGAL      = 5'd2;
	localparam logic [4:0] EXC_BREAKPOINT   = 5'd3;
	localparam logic [4:0] EXC_ECALL_U      = 5'd8;
	localparam logic [4:0] EXC_ECALL_S      = 5'd9;
	localparam logic [4:0] EXC_ECALL_M      = 5'd11;

	localparam logic [4:0] IRQ_S_TIMER = 5'd5;
	localparam logic [4:0] IRQ_M_TIMER = 5'd7;
	localparam logic [4:0] IRQ_S_EXT   = 5'd9;
	localparam logic [4:0] IRQ_M_EXT   = 5'd11;

	// rv32 with I, M and S
	localparam logic [31:0] MISA_VALUE   = 32'h4004_1100;
	localparam logic [31:0] MIE_MASK     = 32'h0000_0AA0;
	localparam logic [31:0] MSTATUS_MASK = 32'h0004_19AA;
	localparam logic [31:0] MEDELEG_MASK = 32'h0000_FFFF;
	localparam logic [31:0] MIDELEG_MASK = 32'h0000_0220;	// only S timer and S ext

	//////////////////////////////////////////////////
	// shared structs

	typedef struct packed
	{
		logic        irq;
		logic [30:0] code;
	} cause_t;

	typedef struct packed
	{
		logic        valid;
		logic [11:0] addr;
		csr_op_t     op;
		logic [31:0] wdata;
	} csr_req_t;

	typedef struct packed
	{
		logic        valid;
		cause_t      cause;
		logic [31:0] pc;
		logic [29:0] insn;	// instruction word [31:2]
	} trap_req_t;

	typedef struct packed
	{
		logic  sie;
		logic  mie;
		logic  spie;
		logic  mpie;
		logic  spp;
		mode_t mpp;
		logic  sum;
	} status_t;

	typedef struct packed
	{
		logic s_timer;
		logic m_timer;
		logic s_ext;
		logic m_ext;
	} irq_lines_t;

	// place the interrupt lines at their mip bit positions
	function automatic logic [31:0] irq_to_mip(input irq_lines_t lines);
		logic [31:0] word;
		word = '0;
		word[IRQ_S_TIMER] = lines.s_timer;
		word[IRQ_M_TIMER] = lines.m_timer;
		word[IRQ_S_EXT]   = lines.s_ext;
		word[IRQ_M_EXT]   = lines.m_ext;
		return word;
	endfunction

endpackage

// File: hdl/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
	input  logic                  clk,
	input  logic                  nrst,
	input  csr_pkg::csr_req_t     csr_req,
	input  csr_pkg::trap_req_t    trap_req,
	input  logic                  take_trap,
	input  logic                  trap_to_s,
	input  logic                  do_mret,
	input  logic                  do_sret,
	input  csr_pkg::mode_t        next_mode,
	input  csr_pkg::irq_lines_t   irq,
	input  logic [63:0]           mtime_hi_lo,
	output logic [31:0]           rdata,
	output csr_pkg::status_t      status,
	output logic [31:0]           mie,
	output logic [31:0]           mideleg,
	output logic [31:0]           medeleg,
	output logic [31:0]           mtvec,
	output logic [31:0]           stvec,
	output logic [31:0]           mepc,
	output logic [31:0]           sepc,
	output csr_pkg::mode_t        cur_mode,
	output logic [1:0]            cmp_we,
	output logic [31:0]           cmp_data
);
	import csr_pkg::*;

	logic [31:0] mscratch;
	logic [31:0] mtval;
	logic [31:0] stval;
	cause_t      mcause;
	cause_t      scause;

	logic [31:0] mstatus_w;
	logic [31:0] ms_w;		// masked mstatus write word
	logic [31:0] new_val;
	logic        wr_en;
	logic        csr_we;
	logic        trap_m;
	logic        trap_s;
	logic [31:0] trap_tval;

	assign mstatus_w = {13'b0, status.sum, 5'b0, status.mpp, 2'b0, status.spp,
		status.mpie, 1'b0, status.spie, 1'b0, status.mie, 1'b0, status.sie, 1'b0};

	//////////////////////////////////////////////////
	// read mux, old value for the op unit

	always_comb
	begin
		case (csr_req.addr)
			CSR_MSTATUS:   rdata = mstatus_w;
			CSR_MISA:      rdata = MISA_VALUE;
			CSR_MIE:       rdata = mie;
			CSR_MIP:       rdata = irq_to_mip(irq);
			CSR_MTVEC:     rdata = mtvec;
			CSR_MSCRATCH:  rdata = mscratch;
			CSR_MEPC:      rdata = mepc;
			CSR_MCAUSE:    rdata = mcause;
			CSR_MTVAL:     rdata = mtval;
			CSR_MEDELEG:   rdata = medeleg;
			CSR_MIDELEG:   rdata = mideleg;
			CSR_STVEC:     rdata = stvec;
			CSR_SEPC:      rdata = sepc;
			CSR_SCAUSE:    rdata = scause;
			CSR_STVAL:     rdata = stval;
			CSR_TIME:      rdata = mtime_hi_lo[31:0];
			CSR_TIMEH:     rdata = mtime_hi_lo[63:32];
			CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID:
				rdata = '0;
			default:       rdata = '0;	// mtimecmp pair reads as zero too
		endcase
	end

	csr_op_unit op_unit_inst (
		.op      (csr_req.op),
		.src     (csr_req.wdata),
		.old     (rdata),
		.new_val (new_val),
		.wr_en   (wr_en)
	);

	// trap beats mret, mret beats sret, any of them drops the write
	assign csr_we = csr_req.valid && wr_en && !take_trap && !do_mret && !do_sret;
	assign trap_m = take_trap && !trap_to_s;
	assign trap_s = take_trap && trap_to_s;
	assign ms_w   = new_val & MSTATUS_MASK;

	assign cmp_we[0] = csr_we && (csr_req.addr == CSR_MTIMECMP);
	assign cmp_we[1] = csr_we && (csr_req.addr == CSR_MTIMECMPH);
	assign cmp_data  = new_val;

	// tval only carries information for fetch misalignment and illegal insn
	always_comb
	begin
		trap_tval = '0;
		if (!trap_req.cause.irq)
		begin
			if (trap_req.cause.code == 31'(EXC_I_MISALIGNED))
				trap_tval = trap_req.pc;
			else if (trap_req.cause.code == 31'(EXC_ILLEGAL))
				trap_tval = {trap_req.insn, 2'b11};
		end
	end

	//////////////////////////////////////////////////
	// mode, mstatus and the control csrs

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cur_mode <= M;
			status   <= '0;
			mie      <= '0;
			mtvec    <= '0;
			stvec    <= '0;
			medeleg  <= '0;
			mideleg  <= '0;
		end
		else
		begin
			cur_mode <= next_mode;	// holds when nothing redirects
			if (trap_m)
			begin
				status.mpie <= status.mie;
				status.mie  <= 1'b0;
				status.mpp  <= cur_mode;
			end
			else if (trap_s)
			begin
				status.spie <= status.sie;
				status.sie  <= 1'b0;
				status.spp  <= (cur_mode != U);
			end
			else if (do_mret)
			begin
				status.mie  <= status.mpie;
				status.mpie <= 1'b1;
				status.mpp  <= U;
			end
			else if (do_sret)
			begin
				status.sie  <= status.spie;
				status.spie <= 1'b1;
				status.spp  <= 1'b0;
			end
			else if (csr_we)
			begin
				case (csr_req.addr)
					CSR_MSTATUS:
					begin
						status.sie  <= ms_w[1];
						status.mie  <= ms_w[3];
						status.spie <= ms_w[5];
						status.mpie <= ms_w[7];
						status.spp  <= ms_w[8];
						status.sum  <= ms_w[18];
						// 2'b10 is reserved, keep the old mode
						if (ms_w[12:11] != 2'b10)
							status.mpp <= mode_t'(ms_w[12:11]);
					end
					CSR_MIE:     mie     <= new_val & MIE_MASK;
					CSR_MTVEC:   mtvec   <= {new_val[31:2], 2'b00};	// direct only
					CSR_STVEC:   stvec   <= {new_val[31:2], 2'b00};
					CSR_MEDELEG: medeleg <= new_val & MEDELEG_MASK;
					CSR_MIDELEG: mideleg <= new_val & MIDELEG_MASK;
					default:     ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// trap payload and scratch

	always_ff @(posedge clk)
	begin
		if (trap_m)
		begin
			mepc   <= {trap_req.pc[31:2], 2'b00};
			mcause <= trap_req.cause;
			mtval  <= trap_tval;
		end
		if (trap_s)
		begin
			sepc   <= {trap_req.pc[31:2], 2'b00};
			scause <= trap_req.cause;
			stval  <= trap_tval;
		end
		if (csr_we)
		begin
			case (csr_req.addr)
				CSR_MSCRATCH: mscratch <= new_val;
				CSR_MEPC:     mepc     <= {new_val[31:2], 2'b00};
				CSR_MCAUSE:   mcause   <= new_val;
				CSR_MTVAL:    mtval    <= new_val;
				CSR_SEPC:     sepc     <= {new_val[31:2], 2'b00};
				CSR_SCAUSE:   scause   <= new_val;
				CSR_STVAL:    stval    <= new_val;
				default:      ;
			endcase
		end
	end

endmodule

// File: hdl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
	input  logic                clk,
	input  logic                nrst,
	input  csr_pkg::csr_req_t   csr_req,
	input  csr_pkg::trap_req_t  trap_req,
	input  logic                mret,
	input  logic                sret,
	input  logic                ext_m,
	input  logic                ext_s,
	output logic [31:0]         rdata,
	output csr_pkg::mode_t      cur_mode,
	output logic                redirect,
	output logic [31:0]         redirect_pc,
	output logic                irq_req,
	output csr_pkg::cause_t     irq_cause
);
	import csr_pkg::*;

	irq_lines_t  irq;
	logic [31:0] mip;
	status_t     status;
	logic [31:0] mie, mideleg, medeleg;
	logic [31:0] mtvec, stvec, mepc, sepc;
	logic        take_trap, trap_to_s, do_mret, do_sret;
	mode_t       next_mode;
	logic [1:0]  cmp_we;
	logic [31:0] cmp_data;
	logic [63:0] mtime;
	logic        m_timer;

	// no supervisor timer in this core
	assign irq = '{s_timer: 1'b0, m_timer: m_timer, s_ext: ext_s, m_ext: ext_m};
	assign mip = irq_to_mip(irq);

	csr_regfile regfile_inst (
		.clk         (clk),
		.nrst        (nrst),
		.csr_req     (csr_req),
		.trap_req    (trap_req),
		.take_trap   (take_trap),
		.trap_to_s   (trap_to_s),
		.do_mret     (do_mret),
		.do_sret     (do_sret),
		.next_mode   (next_mode),
		.irq         (irq),
		.mtime_hi_lo (mtime),
		.rdata       (rdata),
		.status      (status),
		.mie         (mie),
		.mideleg     (mideleg),
		.medeleg     (medeleg),
		.mtvec       (mtvec),
		.stvec       (stvec),
		.mepc        (mepc),
		.sepc        (sepc),
		.cur_mode    (cur_mode),
		.cmp_we      (cmp_we),
		.cmp_data    (cmp_data)
	);

	trap_ctrl trap_ctrl_inst (
		.trap_req    (trap_req),
		.mret        (mret),
		.sret        (sret),
		.status      (status),
		.cur_mode    (cur_mode),
		.mie         (mie),
		.mip         (mip),
		.medeleg     (medeleg),
		.mideleg     (mideleg),
		.mtvec       (mtvec),
		.stvec       (stvec),
		.mepc        (mepc),
		.sepc        (sepc),
		.take_trap   (take_trap),
		.trap_to_s   (trap_to_s),
		.do_mret     (do_mret),
		.do_sret     (do_sret),
		.next_mode   (next_mode),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.irq_req     (irq_req),
		.irq_cause   (irq_cause)
	);

	machine_timer timer_inst (
		.clk      (clk),
		.nrst     (nrst),
		.cmp_we   (cmp_we),
		.cmp_data (cmp_data),
		.mtime    (mtime),
		.m_timer  (m_timer)
	);

endmodule

// File: hdl/machine_timer.sv
`timescale 1ns/1ps

module machine_timer (
	input  logic        clk,
	input  logic        nrst,
	input  logic [1:0]  cmp_we,
	input  logic [31:0] cmp_data,
	output logic [63:0] mtime,
	output logic        m_timer
);

	logic [63:0] mtimecmp;

	//////////////////////////////////////////////////
	// free running counter and compare

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mtime    <= '0;
			mtimecmp <= '1;		// never fires until written
			m_timer  <= 1'b0;
		end
		else
		begin
			mtime <= mtime + 64'd1;
			if (cmp_we[0])
				mtimecmp[31:0] <= cmp_data;
			if (cmp_we[1])
				mtimecmp[63:32] <= cmp_data;	// high half
			// level, drops again once mtimecmp is moved past mtime
			m_timer <= (mtime >= mtimecmp);
		end
	end

endmodule

// File: hdl/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
	input  csr_pkg::trap_req_t trap_req,
	input  logic               mret,
	input  logic               sret,
	input  csr_pkg::status_t   status,
	input  csr_pkg::mode_t     cur_mode,
	input  logic [31:0]        mie,
	input  logic [31:0]        mip,
	input  logic [31:0]        medeleg,
	input  logic [31:0]        mideleg,
	input  logic [31:0]        mtvec,
	input  logic [31:0]        stvec,
	input  logic [31:0]        mepc,
	input  logic [31:0]        sepc,
	output logic               take_trap,
	output logic               trap_to_s,
	output logic               do_mret,
	output logic               do_sret,
	output csr_pkg::mode_t     next_mode,
	output logic               redirect,
	output logic [31:0]        redirect_pc,
	output logic               irq_req,
	output csr_pkg::cause_t    irq_cause
);
	import csr_pkg::*;

	logic        deleg_bit;
	logic        m_ok;
	logic        s_ok;
	logic [31:0] pending;
	logic [31:0] takeable;

	// delegation bit picked by cause code, large codes never delegate
	assign deleg_bit = (trap_req.cause.code[30:5] == '0) &&
		(trap_req.cause.irq ? mideleg[trap_req.cause.code[4:0]]
		                    : medeleg[trap_req.cause.code[4:0]]);

	assign take_trap = trap_req.valid;
	assign trap_to_s = take_trap && deleg_bit && (cur_mode != M);
	assign do_mret   = mret && !take_trap;
	assign do_sret   = sret && !take_trap && !mret;
	assign redirect  = take_trap || do_mret || do_sret;

	always_comb
	begin
		next_mode   = cur_mode;
		redirect_pc = '0;
		if (take_trap)
		begin
			next_mode   = trap_to_s ? S : M;
			redirect_pc = trap_to_s ? stvec : mtvec;
		end
		else if (do_mret)
		begin
			next_mode   = status.mpp;
			redirect_pc = mepc;
		end
		else if (do_sret)
		begin
			next_mode   = status.spp ? S : U;
			redirect_pc = sepc;
		end
	end

	//////////////////////////////////////////////////
	// pending interrupt selection

	assign m_ok     = (cur_mode != M) || status.mie;
	assign s_ok     = (cur_mode == U) || ((cur_mode == S) && status.sie);
	assign pending  = mie & mip;
	assign takeable = pending & ((mideleg & {32{s_ok}}) | (~mideleg & {32{m_ok}}));

	// fixed order M ext, M timer, S ext, S timer
	always_comb
	begin
		irq_req   = 1'b1;
		irq_cause = '0;
		irq_cause.irq = 1'b1;
		if (takeable[IRQ_M_EXT])
			irq_cause.code = 31'(IRQ_M_EXT);
		else if (takeable[IRQ_M_TIMER])
			irq_cause.code = 31'(IRQ_M_TIMER);
		else if (takeable[IRQ_S_EXT])
			irq_cause.code = 31'(IRQ_S_EXT);
		else if (takeable[IRQ_S_TIMER])
			irq_cause.code = 31'(IRQ_S_TIMER);
		else
		begin
			irq_req   = 1'b0;
			irq_cause = '0;
		end
	end

endmodule

// File: include/csr_tb_tasks.svh
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

//////////////////////////////////////////////////
// reference model

// RS and RC with a zero source leave the register alone
function automatic logic [31:0] rmw_model(input csr_op_t op, input logic [31:0] src,
	input logic [31:0] old);
	if (op == RW)
		return src;
	else if (op == RS)
		return old | src;
	else if (op == RC)
		return old & ~src;
	return old;
endfunction

function automatic trap_req_t make_exc(input logic [4:0] code, input logic [31:0] pc,
	input logic [31:0] word);
	trap_req_t tr;
	tr            = '0;
	tr.valid      = 1'b1;
	tr.cause.code = 31'(code);
	tr.pc         = pc;
	tr.insn       = word[31:2];	// low bits are always 2'b11
	return tr;
endfunction

task automatic read_expect(input logic [11:0] addr, input logic [31:0] exp);
	logic [31:0] val;
	csr_access(addr, NONE, '0, val);
	expect_eq(val, exp, $sformatf("csr %h", addr));
endtask

task automatic rmw_and_check(input logic [11:0] addr, input csr_op_t op, input logic [31:0] src,
	input logic [31:0] mask, inout logic [31:0] model);
	logic [31:0] old;
	csr_access(addr, op, src, old);
	expect_eq(old, model, $sformatf("old value of csr %h", addr));
	model = rmw_model(op, src, model) & mask;
endtask

task automatic wait_for_irq(input int bound);
	int n;
	n = 0;
	while (!irq_req && n < bound)
	begin
		@(posedge clk);
		#1;
		n++;
	end
	if (!irq_req)
	begin
		$display("irq_req did not rise within %0d cycles of the mtimecmp write", bound);
		$display("Something failed");
		$fatal(1, "interrupt timeout");
	end
endtask

//////////////////////////////////////////////////
// directed tests

task automatic test_reset_state();
	expect_eq(32'(cur_mode), 32'(M), "mode after reset");
	expect_eq({31'b0, redirect}, 32'd0, "redirect after reset");
	expect_eq({31'b0, irq_req}, 32'd0, "irq_req after reset");
	read_expect(CSR_MISA, MISA_VALUE);
	read_expect(CSR_MVENDORID, 32'h0);
	read_expect(CSR_MARCHID, 32'h0);
	read_expect(CSR_MIMPID, 32'h0);
	read_expect(CSR_MHARTID, 32'h0);
	read_expect(CSR_MSTATUS, 32'h0);
	read_expect(CSR_MIE, 32'h0);
endtask

task automatic test_csr_ops();
	logic [31:0] dummy;
	logic [31:0] data;
	csr_op_t     op;
	int          i;
	// known start values for the model
	csr_access(CSR_MSCRATCH, RW, 32'hA5A5_0F0F, dummy);
	mscratch_model = 32'hA5A5_0F0F;
	rmw_and_check(CSR_MSCRATCH, RW, 32'h1234_5678, '1, mscratch_model);
	rmw_and_check(CSR_MSCRATCH, RS, 32'h0000_00F0, '1, mscratch_model);
	rmw_and_check(CSR_MSCRATCH, RC, 32'h0000_0008, '1, mscratch_model);
	rmw_and_check(CSR_MSCRATCH, RS, 32'h0, '1, mscratch_model);
	read_expect(CSR_MSCRATCH, 32'h1234_56F0);
	mie_model = 32'h0;
	rmw_and_check(CSR_MIE, RW, 32'hFFFF_FFFF, MIE_MASK, mie_model);
	read_expect(CSR_MIE, 32'h0000_0AA0);	// only the four enables stick
	rmw_and_check(CSR_MIE, RC, 32'h0000_0080, MIE_MASK, mie_model);
	rmw_and_check(CSR_MIE, RS, 32'h0, MIE_MASK, mie_model);
	read_expect(CSR_MIE, 32'h0000_0A20);
	csr_access(CSR_MTVAL, RW, 32'h0F0F_0F0F, dummy);
	mtval_model = 32'h0F0F_0F0F;
	for (i = 0; i < RAND_WRITES; i++)
	begin
		op   = csr_op_t'(2'($urandom_range(3, 1)));
		data = $urandom;
		if ($urandom_range(1, 0) == 0)
			rmw_and_check(CSR_MSCRATCH, op, data, '1, mscratch_model);
		else
			rmw_and_check(CSR_MTVAL, op, data, '1, mtval_model);
	end
	read_expect(CSR_MSCRATCH, mscratch_model);
	read_expect(CSR_MTVAL, mtval_model);
endtask

task automatic test_machine_trap();
	logic [31:0] dummy;
	csr_access(CSR_MTVEC, RW, 32'h0000_1000, dummy);
	csr_access(CSR_MSTATUS, RS, 32'h0000_0008, dummy);
	fire_redirect(make_exc(EXC_ILLEGAL, 32'h0000_2468, ILLEGAL_WORD), 1'b0, 1'b0, '0, 32'h1000);
	expect_eq(32'(cur_mode), 32'(M), "mode after illegal trap");
	read_expect(CSR_MEPC, 32'h0000_2468);
	read_expect(CSR_MCAUSE, 32'd2);
	read_expect(CSR_MTVAL, ILLEGAL_WORD);
	read_expect(CSR_MSTATUS, 32'h0000_1880);	// MPP M, MPIE 1, MIE 0
	fire_redirect('0, 1'b1, 1'b0, '0, 32'h0000_2468);
	expect_eq(32'(cur_mode), 32'(M), "mode after mret");
	read_expect(CSR_MSTATUS, 32'h0000_0088);
endtask

task automatic test_delegation();
	logic [31:0] dummy;
	// MPP was left at U by the last mret
	fire_redirect('0, 1'b1, 1'b0, '0, 32'h0000_2468);
	expect_eq(32'(cur_mode), 32'(U), "mode after mret to U");
	csr_access(CSR_STVEC, RW, 32'h0000_3000, dummy);
	csr_access(CSR_MEDELEG, RS, 32'h1 << EXC_ECALL_U, dummy);
	fire_redirect(make_exc(EXC_ECALL_U, 32'h0000_0400, 32'h0000_0073), 1'b0, 1'b0, '0,
		32'h0000_3000);
	expect_eq(32'(cur_mode), 32'(S), "mode after delegated ecall");
	read_expect(CSR_SEPC, 32'h0000_0400);
	read_expect(CSR_SCAUSE, 32'd8);
	read_expect(CSR_STVAL, 32'h0);
	fire_redirect('0, 1'b0, 1'b1, '0, 32'h0000_0400);
	expect_eq(32'(cur_mode), 32'(U), "mode after sret");
	csr_access(CSR_MEDELEG, RC, 32'h1 << EXC_ECALL_U, dummy);
	fire_redirect(make_exc(EXC_ECALL_U, 32'h0000_0404, 32'h0000_0073), 1'b0, 1'b0, '0,
		32'h0000_1000);
	expect_eq(32'(cur_mode), 32'(M), "mode after undelegated ecall");
	read_expect(CSR_MEPC, 32'h0000_0404);
	read_expect(CSR_MCAUSE, 32'd8);
endtask

task automatic test_interrupts();
	logic [31:0] dummy;
	logic [31:0] now;
	csr_req_t    side;
	csr_access(CSR_MIE, RW, 32'h0000_0880, dummy);	// MEIE and MTIE
	csr_access(CSR_MSTATUS, RS, 32'h0000_0008, dummy);
	csr_access(CSR_MTIMECMPH, RW, 32'h0, dummy);
	// a set with zero source must leave mtimecmp alone
	csr_access(CSR_MTIMECMP, RS, 32'h0, dummy);
	csr_access(CSR_TIME, NONE, '0, now);
	expect_eq({31'b0, irq_req}, 32'd0, "irq_req after zero source set of mtimecmp");
	csr_access(CSR_MTIMECMP, RW, now + 32'd40, dummy);
	expect_eq({31'b0, irq_req}, 32'd0, "irq_req before mtime reaches mtimecmp");
	wait_for_irq(IRQ_POLL_BOUND);
	expect_eq(irq_cause, {1'b1, 31'd7}, "timer irq_cause");
	@(posedge clk);
	#1;
	ext_m = 1'b1;
	#2;
	expect_eq({31'b0, irq_req}, 32'd1, "irq_req with ext_m");
	expect_eq(irq_cause, {1'b1, 31'd11}, "irq_cause with ext_m and timer");
	@(posedge clk);
	#1;
	ext_m = 1'b0;
	// the trap wins and the write is dropped
	side = '{valid: 1'b1, addr: CSR_MSCRATCH, op: RW, wdata: ~mscratch_model};
	fire_redirect(make_exc(EXC_ECALL_M, 32'h0000_0500, 32'h0000_0073), 1'b0, 1'b0, side,
		32'h0000_1000);
	read_expect(CSR_MSCRATCH, mscratch_model);
	read_expect(CSR_MCAUSE, 32'd11);
endtask

`endif

// File: tb/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;
	import csr_pkg::*;

	localparam int CLK_PERIOD     = 20;
	localparam int RAND_SEED      = 95791;
	localparam int RAND_WRITES    = 40;
	localparam int IRQ_POLL_BOUND = 100;
	localparam logic [31:0] ILLEGAL_WORD = 32'h8000_1073;

	// rough cycle budget per test, two cycles per csr access
	localparam int RESET_TEST_CYCLES = 30;
	localparam int OPS_TEST_CYCLES   = 2 * (RAND_WRITES + 20);
	localparam int TRAP_TEST_CYCLES  = 30;
	localparam int DELEG_TEST_CYCLES = 40;
	localparam int IRQ_TEST_CYCLES   = 40 + IRQ_POLL_BOUND;
	localparam int WATCHDOG_CYCLES   = RESET_TEST_CYCLES + OPS_TEST_CYCLES + TRAP_TEST_CYCLES
		+ DELEG_TEST_CYCLES + IRQ_TEST_CYCLES + 200;

	logic        clk;
	logic        nrst;
	csr_req_t    csr_req;
	trap_req_t   trap_req;
	logic        mret;
	logic        sret;
	logic        ext_m;
	logic        ext_s;
	logic [31:0] rdata;
	mode_t       cur_mode;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        irq_req;
	cause_t      irq_cause;

	logic [31:0] mscratch_model;
	logic [31:0] mtval_model;
	logic [31:0] mie_model;
	int          err_count;

	csr_unit csr_unit_inst (
		.clk         (clk),
		.nrst        (nrst),
		.csr_req     (csr_req),
		.trap_req    (trap_req),
		.mret        (mret),
		.sret        (sret),
		.ext_m       (ext_m),
		.ext_s       (ext_s),
		.rdata       (rdata),
		.cur_mode    (cur_mode),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.irq_req     (irq_req),
		.irq_cause   (irq_cause)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// drive and compare primitives

	task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else
		begin
			err_count++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// one access, old value sampled mid cycle
	task automatic csr_access(input logic [11:0] addr, input csr_op_t op,
		input logic [31:0] wdata, output logic [31:0] old);
		@(posedge clk);
		#1;
		csr_req = '{valid: 1'b1, addr: addr, op: op, wdata: wdata};
		#2;
		old = rdata;
		@(posedge clk);
		#1;
		csr_req = '0;	// write landed on that edge
	endtask

	// trap, mret or sret strobe with an optional csr request alongside
	task automatic fire_redirect(input trap_req_t tr, input logic m, input logic s,
		input csr_req_t side, input logic [31:0] exp_pc);
		@(posedge clk);
		#1;
		trap_req = tr;
		mret     = m;
		sret     = s;
		csr_req  = side;
		#2;
		expect_eq({31'b0, redirect}, 32'd1, "redirect");
		expect_eq(redirect_pc, exp_pc, "redirect_pc");
		@(posedge clk);
		#1;
		trap_req = '0;
		mret     = 1'b0;
		sret     = 1'b0;
		csr_req  = '0;
	endtask

	`include "csr_tb_tasks.svh"

	//////////////////////////////////////////////////
	// test sequence

	initial
	begin
		void'($urandom(RAND_SEED));
		err_count = 0;
		nrst      = 1'b0;
		csr_req   = '0;
		trap_req  = '0;
		mret      = 1'b0;
		sret      = 1'b0;
		ext_m     = 1'b0;
		ext_s     = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		nrst = 1'b1;

		test_reset_state();
		test_csr_ops();
		test_machine_trap();
		test_delegation();
		test_interrupts();

		if (err_count == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("Something failed");
			$fatal(1, "errors found");
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
		$display("Something failed");
		$fatal(1, "watchdog");
	end

endmodule
